// File: logic/mbox_cfg_pkg.sv
/*
 * datapath sizes and word types shared by both mailbox directions
 * MBOX_DEPTH must be at least 2, DATA_W a multiple of 8
 * the fill count is one bit wider than a buffer index so that full fits
 */
package mbox_cfg_pkg;

  // ------------------------------
  // sizes
  // ------------------------------
  localparam int unsigned MBOX_DEPTH = 8;           // words per direction
  localparam int unsigned DATA_W     = 32;          // register and payload width
  localparam int unsigned STRB_W     = DATA_W / 8;  // one enable per byte

  // width of a buffer index, kept at 1 bit for a degenerate depth
  localparam int unsigned IDX_W = (MBOX_DEPTH > 1) ? $clog2(MBOX_DEPTH) : 1;

  // ------------------------------
  // types
  // ------------------------------
  // one mailbox word, also the register width
  typedef logic [DATA_W-1:0] data_t;

  // byte enables of a register write
  typedef logic [STRB_W-1:0] strb_t;

  // fill count 0..MBOX_DEPTH, thresholds use the same type
  typedef logic [IDX_W:0] usage_t;

endpackage

// File: logic/mbox_reg_pkg.sv
/*
 * register map of one mailbox port, addressed by word index
 * indices above CTRL are unmapped and answer with an error
 * bit positions below are shared by the RTL and the testbench
 */
package mbox_reg_pkg;

  // word index of a register request
  typedef logic [3:0] reg_addr_t;

  // ------------------------------
  // register indices
  // ------------------------------
  typedef enum reg_addr_t {
    MBOXW  = 4'd0,  // push into the outgoing FIFO, write only
    MBOXR  = 4'd1,  // pop from the incoming FIFO, read only
    STATUS = 4'd2,  // FIFO state, read only
    ERROR  = 4'd3,  // sticky errors, clear on read
    WIRQT  = 4'd4,  // write threshold
    RIRQT  = 4'd5,  // read threshold
    IRQS   = 4'd6,  // irq status, write 1 to acknowledge
    IRQEN  = 4'd7,  // irq enable
    IRQP   = 4'd8,  // irq pending, read only
    CTRL   = 4'd9   // flush control, reads 0
  } reg_e;

  // STATUS bits
  localparam int unsigned STAT_R_EMPTY = 0;  // incoming FIFO empty
  localparam int unsigned STAT_W_FULL  = 1;  // outgoing FIFO full
  localparam int unsigned STAT_W_THR   = 2;  // outgoing usage above WIRQT
  localparam int unsigned STAT_R_THR   = 3;  // incoming usage above RIRQT

  // ERROR bits
  localparam int unsigned ERR_R_EMPTY = 0;   // MBOXR read while empty
  localparam int unsigned ERR_W_FULL  = 1;   // MBOXW write while full

  // interrupt bits, same layout in IRQS, IRQEN and IRQP
  localparam int unsigned IRQ_W_THR = 0;
  localparam int unsigned IRQ_R_THR = 1;
  localparam int unsigned IRQ_ERR   = 2;

  typedef logic [2:0] irq_vec_t;

  // CTRL bits
  localparam int unsigned CTRL_FLUSH_W = 0;  // flush outgoing FIFO
  localparam int unsigned CTRL_FLUSH_R = 1;  // flush incoming FIFO

  // ------------------------------
  // fixed read words
  // ------------------------------
  localparam mbox_cfg_pkg::data_t MBOXW_READ_WORD = 32'hFEED_C0DE;
  localparam mbox_cfg_pkg::data_t EMPTY_READ_WORD = 32'hFEED_DEAD;

endpackage

// File: logic/mbox_fifo.sv
/*
 * circular word buffer between the two mailbox ports
 * data_o shows the head word before a pop, it is not fall-through
 * flush wins over a push or pop in the same cycle
 * the producer must not push when full, the consumer must not pop when empty
 */
module mbox_fifo (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 flush_i,  // empties the buffer in one cycle
  input  logic                 push_i,
  input  mbox_cfg_pkg::data_t  data_i,
  input  logic                 pop_i,
  output mbox_cfg_pkg::data_t  data_o,   // head word, meaningful while usage_o != 0
  output mbox_cfg_pkg::usage_t usage_o
);
  import mbox_cfg_pkg::*;

  typedef logic [IDX_W-1:0] ptr_t;

  localparam ptr_t   LAST_IDX = ptr_t'(MBOX_DEPTH - 1);
  localparam usage_t FULL_CNT = usage_t'(MBOX_DEPTH);

  data_t  mem_q [MBOX_DEPTH];  // payload, no reset
  ptr_t   wr_ptr_q;
  ptr_t   rd_ptr_q;
  usage_t usage_q;

  // wrap explicitly, depth need not be a power of two
  function automatic ptr_t ptr_inc(ptr_t p);
    return (p == LAST_IDX) ? '0 : p + ptr_t'(1);
  endfunction

  // ------------------------------
  // pointers and fill count
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push_i, pop_i})
        2'b10:   usage_q <= usage_q + usage_t'(1);
        2'b01:   usage_q <= usage_q - usage_t'(1);
        default: usage_q <= usage_q;  // idle, or push and pop together
      endcase
    end
  end

  // storage, a flushed push is dropped
  always_ff @(posedge clk_i) begin
    if (push_i && !flush_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign usage_o = usage_q;

  // ------------------------------
  // producer and consumer rules
  // ------------------------------
  a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i)
    push_i |-> (usage_q != FULL_CNT))
    else $error("mbox_fifo: push while full");

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> (usage_q != '0))
    else $error("mbox_fifo: pop while empty");

endmodule

// File: logic/mbox_irq_ctrl.sv
/*
 * interrupt status, enable and pending registers of one port
 * irq_o is an active-high level, pending = status and enable
 * an acknowledge never drops an event that is set in the same cycle
 */
module mbox_irq_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  mbox_reg_pkg::irq_vec_t set_i,       // events, one per bit, level or pulse
  input  logic                   ack_i,       // IRQS write
  input  mbox_reg_pkg::irq_vec_t ack_mask_i,  // 1 clears the status bit
  input  logic                   en_we_i,     // IRQEN write
  input  mbox_reg_pkg::irq_vec_t en_i,
  output mbox_reg_pkg::irq_vec_t irqs_o,
  output mbox_reg_pkg::irq_vec_t irqen_o,
  output mbox_reg_pkg::irq_vec_t irqp_o,
  output logic                   irq_o
);
  import mbox_reg_pkg::*;

  irq_vec_t irqs_q;
  irq_vec_t irqs_d;
  irq_vec_t irqen_q;
  irq_vec_t clr_mask;  // bits acknowledged this cycle

  // ------------------------------
  // status update
  // ------------------------------
  assign clr_mask = ack_i ? ack_mask_i : '0;
  assign irqs_d   = (irqs_q & ~clr_mask) | set_i;  // set wins over ack

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      irqs_q  <= '0;
      irqen_q <= '0;
    end else begin
      irqs_q <= irqs_d;
      if (en_we_i) begin
        irqen_q <= en_i;
      end
    end
  end

  // pending and output follow the registers without delay
  assign irqs_o  = irqs_q;
  assign irqen_o = irqen_q;
  assign irqp_o  = irqs_q & irqen_q;
  assign irq_o   = |irqp_o;

  // ------------------------------
  // checks
  // ------------------------------
  a_irq_level: assert property (@(posedge clk_i) disable iff (rst_i)
    irq_o == |(irqs_q & irqen_q))
    else $error("mbox_irq_ctrl: irq_o differs from OR of pending bits");

endmodule

// File: logic/mbox_port.sv
/*
 * register block of one mailbox port, request decoded in the request cycle
 * the response is registered and pulses one cycle after the request
 * one request per cycle at most, there is no back-pressure
 */
module mbox_port (
  input  logic                    clk_i,
  input  logic                    rst_i,
  // register request, one-cycle strobe
  input  logic                    req_i,
  input  logic                    we_i,
  input  mbox_reg_pkg::reg_addr_t addr_i,
  input  mbox_cfg_pkg::data_t     wdata_i,
  input  mbox_cfg_pkg::strb_t     wstrb_i,
  // registered response
  output logic                    rsp_valid_o,
  output mbox_cfg_pkg::data_t     rdata_o,
  output logic                    err_o,
  output logic                    irq_o,
  // outgoing FIFO, this port is the producer
  output mbox_cfg_pkg::data_t     tx_data_o,
  output logic                    tx_push_o,
  output logic                    tx_flush_o,
  input  mbox_cfg_pkg::usage_t    tx_usage_i,
  // incoming FIFO, this port is the consumer
  input  mbox_cfg_pkg::data_t     rx_data_i,
  output logic                    rx_pop_o,
  output logic                    rx_flush_o,
  input  mbox_cfg_pkg::usage_t    rx_usage_i
);
  import mbox_cfg_pkg::*;
  import mbox_reg_pkg::*;

  localparam usage_t THR_MAX = usage_t'(MBOX_DEPTH - 1);  // fires when completely full

  logic       tx_full;
  logic       rx_empty;
  logic [3:0] status;            // built from usage, not stored
  logic [1:0] error_q, error_d;
  logic [1:0] err_new;           // errors raised by this request
  logic       err_clr;           // ERROR read
  usage_t     wirqt_q, wirqt_d;
  usage_t     rirqt_q, rirqt_d;
  irq_vec_t   irq_set;
  irq_vec_t   irqs, irqen, irqp;
  logic       irq_ack;
  logic       irqen_we;
  data_t      wdata_m;           // write data with unstrobed bytes zeroed
  data_t      rsp_data_d, rsp_data_q;
  logic       rsp_err_d, rsp_err_q;
  logic       rsp_valid_q;

  function automatic data_t mask_bytes(data_t d, strb_t s);
    data_t m;
    for (int i = 0; i < STRB_W; i++) begin
      m[i*8 +: 8] = s[i] ? d[i*8 +: 8] : 8'h00;
    end
    return m;
  endfunction

  // thresholds above depth-1 could never trigger
  function automatic usage_t clamp_thr(data_t v);
    return (v > data_t'(THR_MAX)) ? THR_MAX : usage_t'(v);
  endfunction

  // ------------------------------
  // status and irq events
  // ------------------------------
  assign tx_full  = (tx_usage_i == usage_t'(MBOX_DEPTH));
  assign rx_empty = (rx_usage_i == '0);

  always_comb begin
    status               = '0;
    status[STAT_R_EMPTY] = rx_empty;
    status[STAT_W_FULL]  = tx_full;
    status[STAT_W_THR]   = (tx_usage_i > wirqt_q);  // strictly above
    status[STAT_R_THR]   = (rx_usage_i > rirqt_q);
    irq_set              = '0;
    irq_set[IRQ_W_THR]   = status[STAT_W_THR];  // level, re-sets after ack while above
    irq_set[IRQ_R_THR]   = status[STAT_R_THR];
    irq_set[IRQ_ERR]     = |err_new;
  end

  assign wdata_m   = mask_bytes(wdata_i, wstrb_i);
  assign tx_data_o = wdata_m;

  // ------------------------------
  // request decode
  // ------------------------------
  always_comb begin
    tx_push_o  = 1'b0;
    tx_flush_o = 1'b0;
    rx_pop_o   = 1'b0;
    rx_flush_o = 1'b0;
    wirqt_d    = wirqt_q;
    rirqt_d    = rirqt_q;
    irq_ack    = 1'b0;
    irqen_we   = 1'b0;
    err_new    = '0;
    err_clr    = 1'b0;
    rsp_data_d = '0;
    rsp_err_d  = 1'b0;
    if (req_i && we_i) begin
      case (addr_i)
        MBOXW: begin
          if (tx_full) begin
            err_new[ERR_W_FULL] = 1'b1;  // word dropped
            rsp_err_d           = 1'b1;
          end else begin
            tx_push_o = 1'b1;
          end
        end
        WIRQT: wirqt_d  = clamp_thr(wdata_m);
        RIRQT: rirqt_d  = clamp_thr(wdata_m);
        IRQS:  irq_ack  = wstrb_i[0];
        IRQEN: irqen_we = wstrb_i[0];
        CTRL: begin
          tx_flush_o = wstrb_i[0] & wdata_i[CTRL_FLUSH_W];
          rx_flush_o = wstrb_i[0] & wdata_i[CTRL_FLUSH_R];
        end
        default: rsp_err_d = 1'b1;  // read-only or unmapped
      endcase
    end else if (req_i) begin
      case (addr_i)
        MBOXW: rsp_data_d = MBOXW_READ_WORD;
        MBOXR: begin
          if (rx_empty) begin
            rsp_data_d           = EMPTY_READ_WORD;
            rsp_err_d            = 1'b1;
            err_new[ERR_R_EMPTY] = 1'b1;
          end else begin
            rsp_data_d = rx_data_i;  // head word, popped this cycle
            rx_pop_o   = 1'b1;
          end
        end
        STATUS: rsp_data_d = data_t'(status);
        ERROR: begin
          rsp_data_d = data_t'(error_q);
          err_clr    = 1'b1;
        end
        WIRQT:   rsp_data_d = data_t'(wirqt_q);
        RIRQT:   rsp_data_d = data_t'(rirqt_q);
        IRQS:    rsp_data_d = data_t'(irqs);
        IRQEN:   rsp_data_d = data_t'(irqen);
        IRQP:    rsp_data_d = data_t'(irqp);
        CTRL:    rsp_data_d = '0;    // flush bits are self-clearing
        default: rsp_err_d  = 1'b1;  // unmapped index
      endcase
    end
  end

  // a new error in the clearing cycle survives the clear
  assign error_d = (err_clr ? 2'b00 : error_q) | err_new;

  // ------------------------------
  // registers and response
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      error_q     <= '0;
      wirqt_q     <= '0;
      rirqt_q     <= '0;
      rsp_valid_q <= 1'b0;
      rsp_err_q   <= 1'b0;
    end else begin
      error_q     <= error_d;
      wirqt_q     <= wirqt_d;
      rirqt_q     <= rirqt_d;
      rsp_valid_q <= req_i;
      rsp_err_q   <= rsp_err_d;  // low between responses
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rsp_data_q <= rsp_data_d;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rdata_o     = rsp_data_q;
  assign err_o       = rsp_err_q;

  mbox_irq_ctrl u_irq (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .set_i      (irq_set),
    .ack_i      (irq_ack),
    .ack_mask_i (wdata_i[IRQ_ERR:0]),
    .en_we_i    (irqen_we),
    .en_i       (wdata_i[IRQ_ERR:0]),
    .irqs_o     (irqs),
    .irqen_o    (irqen),
    .irqp_o     (irqp),
    .irq_o      (irq_o)
  );

endmodule

// File: logic/mbox_top.sv
/*
 * two-port mailbox, each port writes one FIFO and reads the other
 * a response follows its request by exactly one cycle
 * interrupts are active-high levels
 */
module mbox_top (
  input  logic                    clk_i,
  input  logic                    rst_i,
  // port 0
  input  logic                    p0_req_i,
  input  logic                    p0_we_i,
  input  mbox_reg_pkg::reg_addr_t p0_addr_i,
  input  mbox_cfg_pkg::data_t     p0_wdata_i,
  input  mbox_cfg_pkg::strb_t     p0_wstrb_i,
  output logic                    p0_rsp_valid_o,
  output mbox_cfg_pkg::data_t     p0_rdata_o,
  output logic                    p0_err_o,
  output logic                    p0_irq_o,
  // port 1
  input  logic                    p1_req_i,
  input  logic                    p1_we_i,
  input  mbox_reg_pkg::reg_addr_t p1_addr_i,
  input  mbox_cfg_pkg::data_t     p1_wdata_i,
  input  mbox_cfg_pkg::strb_t     p1_wstrb_i,
  output logic                    p1_rsp_valid_o,
  output mbox_cfg_pkg::data_t     p1_rdata_o,
  output logic                    p1_err_o,
  output logic                    p1_irq_o
);
  import mbox_cfg_pkg::*;

  // ------------------------------
  // port side strobes
  // ------------------------------
  data_t  p0_tx_data, p1_tx_data;
  logic   p0_tx_push, p1_tx_push;
  logic   p0_tx_flush, p1_tx_flush;
  logic   p0_rx_pop, p1_rx_pop;
  logic   p0_rx_flush, p1_rx_flush;

  // FIFO side, named by direction
  data_t  q01_head, q10_head;
  usage_t q01_usage, q10_usage;

  mbox_port port0 (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (p0_req_i),
    .we_i        (p0_we_i),
    .addr_i      (p0_addr_i),
    .wdata_i     (p0_wdata_i),
    .wstrb_i     (p0_wstrb_i),
    .rsp_valid_o (p0_rsp_valid_o),
    .rdata_o     (p0_rdata_o),
    .err_o       (p0_err_o),
    .irq_o       (p0_irq_o),
    .tx_data_o   (p0_tx_data),
    .tx_push_o   (p0_tx_push),
    .tx_flush_o  (p0_tx_flush),
    .tx_usage_i  (q01_usage),   // writes 0->1
    .rx_data_i   (q10_head),    // reads 1->0
    .rx_pop_o    (p0_rx_pop),
    .rx_flush_o  (p0_rx_flush),
    .rx_usage_i  (q10_usage)
  );

  mbox_port port1 (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (p1_req_i),
    .we_i        (p1_we_i),
    .addr_i      (p1_addr_i),
    .wdata_i     (p1_wdata_i),
    .wstrb_i     (p1_wstrb_i),
    .rsp_valid_o (p1_rsp_valid_o),
    .rdata_o     (p1_rdata_o),
    .err_o       (p1_err_o),
    .irq_o       (p1_irq_o),
    .tx_data_o   (p1_tx_data),
    .tx_push_o   (p1_tx_push),
    .tx_flush_o  (p1_tx_flush),
    .tx_usage_i  (q10_usage),   // writes 1->0
    .rx_data_i   (q01_head),    // reads 0->1
    .rx_pop_o    (p1_rx_pop),
    .rx_flush_o  (p1_rx_flush),
    .rx_usage_i  (q01_usage)
  );

  // ------------------------------
  // buffers, either side may flush
  // ------------------------------
  mbox_fifo fifo_0to1 (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .flush_i (p0_tx_flush | p1_rx_flush),
    .push_i  (p0_tx_push),
    .data_i  (p0_tx_data),
    .pop_i   (p1_rx_pop),
    .data_o  (q01_head),
    .usage_o (q01_usage)
  );

  mbox_fifo fifo_1to0 (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .flush_i (p1_tx_flush | p0_rx_flush),
    .push_i  (p1_tx_push),
    .data_i  (p1_tx_data),
    .pop_i   (p0_rx_pop),
    .data_o  (q10_head),
    .usage_o (q10_usage)
  );

endmodule

// File: test/mbox_tb.sv
/*
 * directed testbench for the two-port mailbox
 * one request at a time, each response expected exactly one cycle later
 * the first failing check ends the run
 */
module mbox_tb;
  import mbox_cfg_pkg::*;
  import mbox_reg_pkg::*;

  localparam int TIMEOUT_CYCLES = 3000;  // about ten times the full test length

  logic      clk_i;
  logic      rst_i;
  logic      p0_req_i, p1_req_i;
  logic      p0_we_i, p1_we_i;
  reg_addr_t p0_addr_i, p1_addr_i;
  data_t     p0_wdata_i, p1_wdata_i;
  strb_t     p0_wstrb_i, p1_wstrb_i;
  logic      p0_rsp_valid_o, p1_rsp_valid_o;
  data_t     p0_rdata_o, p1_rdata_o;
  logic      p0_err_o, p1_err_o;
  logic      p0_irq_o, p1_irq_o;
  int        cycle_cnt = 0;

  mbox_top dut0 (.*);

  always #5 clk_i = ~clk_i;

  // ------------------------------
  // failure and compare helpers
  // ------------------------------
  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_data(input string what, input data_t got, input data_t exp);
    if (got !== exp)
      stop_on_error($sformatf("MISMATCH at %0t: %s, got %h expected %h", $time, what, got, exp));
  endtask

  task automatic check_err(input string what, input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("MISMATCH at %0t: %s, err %b expected %b", $time, what, got, exp));
  endtask

  task automatic check_irq(input string what, input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("MISMATCH at %0t: %s, irq %b expected %b", $time, what, got, exp));
  endtask

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
      stop_on_error($sformatf("timeout: tests still running after %0d cycles", cycle_cnt));
  end

  // ------------------------------
  // expected values from the register rules
  // ------------------------------
  function automatic data_t bit_word(input int b);
    return data_t'(1) << b;
  endfunction

  // unstrobed bytes of a pushed word arrive as zero
  function automatic data_t strobed(input data_t d, input strb_t s);
    data_t keep;
    keep = '0;
    for (int i = 0; i < STRB_W; i++) begin
      keep[i*8 +: 8] = {8{s[i]}};
    end
    return d & keep;
  endfunction

  function automatic data_t exp_status(input int tx_used, input int rx_used,
                                       input int wthr, input int rthr);
    data_t s;
    s               = '0;
    s[STAT_R_EMPTY] = (rx_used == 0);
    s[STAT_W_FULL]  = (tx_used == MBOX_DEPTH);
    s[STAT_W_THR]   = (tx_used > wthr);  // strictly above the threshold
    s[STAT_R_THR]   = (rx_used > rthr);
    return s;
  endfunction

  // ------------------------------
  // register access
  // ------------------------------
  task automatic access(input int port, input logic we, input reg_addr_t addr,
                        input data_t wdata, input strb_t strb,
                        output data_t rdata, output logic err);
    logic valid;
    @(posedge clk_i);
    if (port == 0) begin
      p0_req_i   <= 1'b1;
      p0_we_i    <= we;
      p0_addr_i  <= addr;
      p0_wdata_i <= wdata;
      p0_wstrb_i <= strb;
    end else begin
      p1_req_i   <= 1'b1;
      p1_we_i    <= we;
      p1_addr_i  <= addr;
      p1_wdata_i <= wdata;
      p1_wstrb_i <= strb;
    end
    @(posedge clk_i);  // request taken here, strobe drops
    p0_req_i <= 1'b0;
    p1_req_i <= 1'b0;
    @(negedge clk_i);  // response is stable mid cycle
    valid = (port == 0) ? p0_rsp_valid_o : p1_rsp_valid_o;
    rdata = (port == 0) ? p0_rdata_o : p1_rdata_o;
    err   = (port == 0) ? p0_err_o : p1_err_o;
    if (valid !== 1'b1)
      stop_on_error($sformatf("port %0d gave no response one cycle after its request", port));
  endtask

  task automatic reg_write(input int port, input reg_addr_t addr, input data_t wdata,
                           input strb_t strb, output logic err);
    data_t unused;
    access(port, 1'b1, addr, wdata, strb, unused, err);
  endtask

  task automatic reg_read(input int port, input reg_addr_t addr,
                          output data_t rdata, output logic err);
    access(port, 1'b0, addr, '0, '0, rdata, err);
  endtask

  task automatic write_ok(input int port, input reg_addr_t addr, input data_t wdata,
                          input string what);
    logic err;
    reg_write(port, addr, wdata, '1, err);
    check_err(what, err, 1'b0);
  endtask

  task automatic read_expect(input int port, input reg_addr_t addr, input data_t exp,
                             input logic exp_err, input string what);
    data_t rd;
    logic  err;
    reg_read(port, addr, rd, err);
    check_err(what, err, exp_err);
    check_data(what, rd, exp);
  endtask

  // pops n words on the reader port and compares them in order
  task automatic drain(input int port, input int n, inout data_t sent[$]);
    for (int i = 0; i < n; i++) begin
      read_expect(port, MBOXR, sent.pop_front(), 1'b0, "mailbox word order");
    end
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic reset_state_test();
    for (int p = 0; p < 2; p++) begin
      read_expect(p, STATUS, exp_status(0, 0, 0, 0), 1'b0, "STATUS after reset");
      read_expect(p, ERROR, '0, 1'b0, "ERROR after reset");
      read_expect(p, IRQS, '0, 1'b0, "IRQS after reset");
      read_expect(p, CTRL, '0, 1'b0, "CTRL after reset");
      read_expect(p, MBOXW, MBOXW_READ_WORD, 1'b0, "MBOXW read word");
      check_irq("irq after reset", (p == 0) ? p0_irq_o : p1_irq_o, 1'b0);
    end
  endtask

  task automatic transfer_test();
    data_t sent[$];
    data_t w;
    strb_t s;
    logic  err;
    for (int dir = 0; dir < 2; dir++) begin  // 0 to 1, then back
      for (int i = 0; i < 6; i++) begin
        w = $urandom();
        s = (i % 2 == 0) ? '1 : strb_t'($urandom_range(1, 14));  // odd words partial
        reg_write(dir, MBOXW, w, s, err);
        check_err("transfer push", err, 1'b0);
        sent.push_back(strobed(w, s));
      end
      drain(1 - dir, 6, sent);
    end
  endtask

  task automatic overflow_test();
    data_t sent[$];
    data_t w;
    data_t rd;
    logic  err;
    for (int i = 0; i <= MBOX_DEPTH; i++) begin
      w = $urandom();
      reg_write(0, MBOXW, w, '1, err);
      check_err("push into FIFO 0->1", err, (i == MBOX_DEPTH));  // only the extra word errs
      if (i < MBOX_DEPTH)
        sent.push_back(w);
    end
    read_expect(0, STATUS, exp_status(MBOX_DEPTH, 0, 0, 0), 1'b0, "STATUS when full");
    drain(1, MBOX_DEPTH, sent);
    read_expect(1, MBOXR, EMPTY_READ_WORD, 1'b1, "port 1 read of empty FIFO");
    read_expect(0, MBOXR, EMPTY_READ_WORD, 1'b1, "port 0 read of empty FIFO");
    read_expect(0, ERROR, bit_word(ERR_R_EMPTY) | bit_word(ERR_W_FULL), 1'b0, "ERROR both");
    read_expect(0, ERROR, '0, 1'b0, "ERROR cleared by read");
    read_expect(1, ERROR, bit_word(ERR_R_EMPTY), 1'b0, "port 1 ERROR");
    reg_read(0, IRQS, rd, err);
    check_data("IRQS error bit", rd & bit_word(IRQ_ERR), bit_word(IRQ_ERR));
  endtask

  task automatic threshold_irq_test();
    data_t sent[$];
    data_t irq_all;
    data_t w;
    irq_all = bit_word(IRQ_W_THR) | bit_word(IRQ_R_THR) | bit_word(IRQ_ERR);
    write_ok(0, WIRQT, 100, "WIRQT write");
    read_expect(0, WIRQT, data_t'(MBOX_DEPTH - 1), 1'b0, "WIRQT clamped");
    write_ok(0, WIRQT, 2, "WIRQT write");
    write_ok(1, RIRQT, 2, "RIRQT write");
    write_ok(0, IRQS, irq_all, "IRQS ack");  // both FIFOs empty, stale bits go
    write_ok(1, IRQS, irq_all, "IRQS ack");
    write_ok(0, IRQEN, irq_all, "IRQEN write");
    write_ok(1, IRQEN, irq_all, "IRQEN write");
    for (int i = 0; i < 3; i++) begin
      w = $urandom();
      write_ok(0, MBOXW, w, "threshold push");
      sent.push_back(w);
      if (i == 1) begin
        read_expect(0, IRQP, '0, 1'b0, "IRQP at threshold");  // usage 2 is not above 2
        check_irq("p0 irq at threshold", p0_irq_o, 1'b0);
      end
    end
    read_expect(0, IRQP, bit_word(IRQ_W_THR), 1'b0, "port 0 IRQP above threshold");
    check_irq("p0 irq above threshold", p0_irq_o, 1'b1);
    read_expect(1, IRQP, bit_word(IRQ_R_THR), 1'b0, "port 1 IRQP above threshold");
    check_irq("p1 irq above threshold", p1_irq_o, 1'b1);
    drain(1, 3, sent);
    write_ok(0, IRQS, irq_all, "IRQS ack");
    write_ok(1, IRQS, irq_all, "IRQS ack");
    check_irq("p0 irq after ack", p0_irq_o, 1'b0);
    check_irq("p1 irq after ack", p1_irq_o, 1'b0);
    read_expect(0, IRQS, '0, 1'b0, "IRQS after ack");
    // event recorded but masked
    write_ok(0, IRQEN, '0, "IRQEN clear");
    for (int i = 0; i < 3; i++) begin
      w = $urandom();
      write_ok(0, MBOXW, w, "masked push");
      sent.push_back(w);
    end
    read_expect(0, IRQS, bit_word(IRQ_W_THR), 1'b0, "IRQS with irq masked");
    check_irq("p0 irq while masked", p0_irq_o, 1'b0);
    drain(1, 3, sent);
    write_ok(0, IRQS, irq_all, "IRQS ack");
    write_ok(1, IRQS, irq_all, "IRQS ack");
    write_ok(1, IRQEN, '0, "IRQEN clear");
  endtask

  task automatic flush_test();
    for (int i = 0; i < 3; i++) begin
      write_ok(0, MBOXW, $urandom(), "push before flush");
    end
    read_expect(1, STATUS, exp_status(0, 3, 0, 2), 1'b0, "port 1 STATUS before flush");
    write_ok(0, CTRL, bit_word(CTRL_FLUSH_W), "CTRL write flush");
    read_expect(1, STATUS, exp_status(0, 0, 0, 2), 1'b0, "port 1 STATUS after flush");
    read_expect(1, MBOXR, EMPTY_READ_WORD, 1'b1, "read after flush");
    read_expect(1, ERROR, bit_word(ERR_R_EMPTY), 1'b0, "ERROR after flushed read");
  endtask

  task automatic bad_access_test();
    data_t rd;
    logic  err;
    write_ok(0, WIRQT, 5, "WIRQT write");
    access(0, 1'b1, STATUS, '1, '1, rd, err);
    check_err("write to STATUS", err, 1'b1);
    check_data("write to STATUS data", rd, '0);
    access(0, 1'b0, reg_addr_t'(12), '0, '0, rd, err);
    check_err("read of index 12", err, 1'b1);
    check_data("read of index 12 data", rd, '0);
    read_expect(0, WIRQT, 5, 1'b0, "WIRQT kept");
    read_expect(0, STATUS, exp_status(0, 0, 5, 0), 1'b0, "STATUS kept");
    read_expect(0, ERROR, '0, 1'b0, "ERROR untouched by bad access");
  endtask

  // ------------------------------
  // sequence
  // ------------------------------
  initial begin
    void'($urandom(27));  // fixed seed for the whole run
    clk_i      = 1'b0;
    rst_i      = 1'b1;
    p0_req_i   = 1'b0;
    p0_we_i    = 1'b0;
    p0_addr_i  = '0;
    p0_wdata_i = '0;
    p0_wstrb_i = '0;
    p1_req_i   = 1'b0;
    p1_we_i    = 1'b0;
    p1_addr_i  = '0;
    p1_wdata_i = '0;
    p1_wstrb_i = '0;
    repeat (16) @(posedge clk_i);
    rst_i <= 1'b0;
    reset_state_test();
    transfer_test();
    overflow_test();
    threshold_irq_test();
    flush_test();
    bad_access_test();
    $display("Test OK");
    $finish;
  end

endmodule

// File: mailbox.f
logic/mbox_cfg_pkg.sv
logic/mbox_reg_pkg.sv
logic/mbox_fifo.sv
logic/mbox_irq_ctrl.sv
logic/mbox_port.sv
logic/mbox_top.sv
test/mbox_tb.sv

// File: run.sh
#!/bin/sh
# builds the mailbox testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module mbox_tb -f mailbox.f &&
./obj_dir/Vmbox_tb | awk '{ print } /^Test OK$/ { ok = 1 } END { exit !ok }' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
